// File: dram_fifo.f
verilog/dram_fifo_pkg.sv
verilog/axi_burst_pkg.sv
verilog/burst_cmd_if.sv
verilog/stream_fifo.sv
verilog/burst_scheduler.sv
verilog/occupancy_tracker.sv
verilog/axi_burst_master.sv
verilog/dram_fifo_top.sv
dv/dram_fifo_asserts.sv
dv/dram_fifo_tb.sv

// File: dv/dram_fifo_asserts.sv
/* Checks assume the bench streams a word counter from zero and keeps base,
   mask and timeout constant */
`timescale 1ns/10ps
module dram_fifo_asserts import dram_fifo_pkg::*, axi_burst_pkg::*; (
   input logic  dram_clk,
   input logic  input_timeout_reset,
   input addr_t i_base_addr,
   input addr_t i_addr_mask,
   input word_t o_tdata,
   input logic  o_tvalid,
   input logic  o_tready,
   input addr_t o_awaddr,
   input len_t  o_awlen,
   input logic  o_awvalid,
   input logic  o_wlast,
   input logic  o_wvalid,
   input logic  i_wready,
   input logic  i_bvalid,
   input logic  o_bready,
   input addr_t o_araddr,
   input len_t  o_arlen,
   input logic  o_arvalid
);

   logic        failed = 1'b0;                   // Sticky, watched by the bench
   logic        rst_q;                           // Reset one cycle late
   int unsigned out_count;                       // Words delivered so far
   logic [8:0]  w_beats;                         // Beats taken in this write burst

   always_ff @(posedge dram_clk) begin
      rst_q <= input_timeout_reset;
      if (input_timeout_reset) begin
         out_count <= 0;
         w_beats   <= '0;
      end else begin
         if (o_tvalid && o_tready) out_count <= out_count + 1;
         if (o_wvalid && i_wready) w_beats <= o_wlast ? 9'd0 : w_beats + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stream order

   a_order: assert property (@(posedge dram_clk) disable iff (input_timeout_reset)
      (o_tvalid && o_tready) |-> (o_tdata == word_t'(out_count)))
   else begin
      $error("CHECK FAILED at %0t: o_tdata expected %0h got %0h",
             $time, $sampled(out_count), $sampled(o_tdata));
      failed = 1'b1;
   end

   //////////////////////////////////////////////////////////////////////
   // AXI bursts stay in the region and inside one 4 KB page

   a_aw_burst: assert property (@(posedge dram_clk) disable iff (input_timeout_reset)
      o_awvalid |-> (((o_awaddr & i_addr_mask) == (i_base_addr & i_addr_mask))
                 && (14'(o_awaddr[11:0]) + ((14'(o_awlen) + 14'd1) << WORD_SHIFT)
                     <= 14'(PAGE_BYTES))))
   else begin
      $error("Write burst leaves the region or crosses a 4 KB page");
      failed = 1'b1;
   end

   a_ar_burst: assert property (@(posedge dram_clk) disable iff (input_timeout_reset)
      o_arvalid |-> (((o_araddr & i_addr_mask) == (i_base_addr & i_addr_mask))
                 && (14'(o_araddr[11:0]) + ((14'(o_arlen) + 14'd1) << WORD_SHIFT)
                     <= 14'(PAGE_BYTES))))
   else begin
      $error("Read burst leaves the region or crosses a 4 KB page");
      failed = 1'b1;
   end

   // Last flag only on beat awlen+1, never past it
   a_wlast: assert property (@(posedge dram_clk) disable iff (input_timeout_reset)
      (o_wvalid && i_wready) |-> ((w_beats <= {1'b0, o_awlen})
                               && (o_wlast == (w_beats == {1'b0, o_awlen}))))
   else begin
      $error("Write burst has wlast on the wrong beat or runs past awlen");
      failed = 1'b1;
   end

   // B pulse from memory is taken in the cycle it shows
   a_bready: assert property (@(posedge dram_clk) disable iff (input_timeout_reset)
      i_bvalid |-> o_bready)
   else begin
      $error("Write response offered while bready is low");
      failed = 1'b1;
   end

   // Nothing valid right after reset
   a_reset_idle: assert property (@(posedge dram_clk)
      (rst_q && !input_timeout_reset) |-> !(o_awvalid || o_wvalid || o_arvalid || o_tvalid))
   else begin
      $error("A valid output is high in the first cycle after reset");
      failed = 1'b1;
   end

endmodule

bind dram_fifo_top dram_fifo_asserts checks (.*);

// File: dv/dram_fifo_tb.sv
/* Drives a counting word stream through the DUT against a sparse AXI memory.
   Checking lives in the bound assertions plus a final word count */
`timescale 1ns/10ps
module dram_fifo_tb import dram_fifo_pkg::*, axi_burst_pkg::*; ();

   localparam int          RESET_CYCLES    = 10;
   localparam int          STREAM_WORDS    = 3000;          // Wraps the 16 KB region
   localparam int          TAIL_WORDS      = 5;             // Comes back only by timeout
   localparam int          TOTAL_WORDS     = STREAM_WORDS + TAIL_WORDS;
   localparam int          WATCHDOG_CYCLES = 200 * TOTAL_WORDS;
   localparam int          IDLE_CYCLES     = 100;           // Quiet window before the count
   localparam addr_t       BASE_ADDR       = 30'h0001_0000;
   localparam addr_t       ADDR_MASK       = 30'h3FFF_C000; // Low 14 bits wrap
   localparam logic [11:0] TIMEOUT         = 12'd40;

   logic        dram_clk            = 1'b0;
   logic        input_timeout_reset = 1'b1;
   addr_t       i_base_addr         = BASE_ADDR;
   addr_t       i_addr_mask         = ADDR_MASK;
   logic [11:0] i_timeout           = TIMEOUT;
   word_t       i_tdata             = '0;
   logic        i_tvalid            = 1'b0;
   logic        o_tready            = 1'b0;
   logic        i_awready           = 1'b0;
   logic        i_wready            = 1'b0;
   logic        i_bvalid            = 1'b0;
   logic        i_arready           = 1'b0;
   word_t       i_rdata             = '0;
   logic        i_rlast             = 1'b0;
   logic        i_rvalid            = 1'b0;
   logic        i_tready;
   word_t       o_tdata;
   logic        o_tvalid;
   addr_t       o_awaddr;
   len_t        o_awlen;
   logic        o_awvalid;
   word_t       o_wdata;
   logic        o_wlast;
   logic        o_wvalid;
   logic        o_bready;
   addr_t       o_araddr;
   len_t        o_arlen;
   logic        o_arvalid;
   logic        o_rready;

   word_t       dram_mem [logic [31:0]];          // Sparse DRAM, word addressed
   logic [31:0] wr_word;                          // Next write beat lands here
   logic [31:0] rd_word;                          // Next read beat comes from here
   int          rd_left;                          // Read beats still owed
   int          b_wait;                           // Cycles until B
   logic [31:0] lfsr = 32'hb2f2;
   logic        valid_gate = 1'b0;                // Random offer for the input stream
   int          sent = 0;                         // Words taken by the DUT
   int          delivered;                        // Words taken from the DUT

   dram_fifo_top i_dut (.*);

   initial forever #4 dram_clk = ~dram_clk;      // 8 ns

   // Galois step, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One fresh bit per random choice
   always @(posedge dram_clk) begin
      lfsr = lfsr_next(lfsr);
      valid_gate <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      o_tready <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      i_awready <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      i_wready <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      i_arready <= lfsr[0];
   end

   //////////////////////////////////////////////////////////////////////
   // AXI memory model

   always @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         i_bvalid <= 1'b0;
         b_wait = 0;
      end else begin
         i_bvalid <= 1'b0;
         if (b_wait != 0) begin
            b_wait = b_wait - 1;
            if (b_wait == 0) i_bvalid <= 1'b1;   // Two cycles after wlast
         end
         if (o_awvalid && i_awready) wr_word = 32'(o_awaddr >> WORD_SHIFT);
         if (o_wvalid && i_wready) begin
            dram_mem[wr_word] = o_wdata;
            wr_word = wr_word + 1;
            if (o_wlast) b_wait = 2;
         end
      end
   end

   always @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         i_rvalid <= 1'b0;
         i_rlast  <= 1'b0;
         rd_left = 0;
      end else begin
         if (i_rvalid && o_rready) begin       // Beat taken, move on
            rd_word = rd_word + 1;
            rd_left = rd_left - 1;
         end
         if (o_arvalid && i_arready) begin
            rd_word = 32'(o_araddr >> WORD_SHIFT);
            rd_left = int'(o_arlen) + 1;
         end
         i_rvalid <= (rd_left != 0);
         i_rlast  <= (rd_left == 1);
         if (rd_left != 0) i_rdata <= dram_mem[rd_word];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stream stimulus and bookkeeping

   always @(posedge dram_clk) begin
      if (input_timeout_reset) delivered <= 0;
      else if (o_tvalid && o_tready) delivered <= delivered + 1;
   end

   // Offer counter words until target words in total are taken
   task automatic send_words(input int target);
      while (sent < target) begin
         @(posedge dram_clk);
         if (i_tvalid && i_tready) sent = sent + 1;
         if (sent < target && (valid_gate || (i_tvalid && !i_tready))) begin
            i_tvalid <= 1'b1;
            i_tdata  <= word_t'(sent);          // Held while stalled
         end else begin
            i_tvalid <= 1'b0;
         end
      end
   endtask

   task automatic wait_delivered(input int count);
      while (delivered < count) @(posedge dram_clk);
   endtask

   initial begin
      repeat (RESET_CYCLES) @(posedge dram_clk);
      input_timeout_reset <= 1'b0;
      send_words(STREAM_WORDS);
      wait_delivered(STREAM_WORDS);               // Gap until the long run is back
      send_words(TOTAL_WORDS);
      wait_delivered(TOTAL_WORDS);
      repeat (IDLE_CYCLES) @(posedge dram_clk);
      if (delivered != TOTAL_WORDS) begin
         $display("CHECK FAILED at %0t: delivered count expected %0d got %0d",
                  $time, TOTAL_WORDS, delivered);
      end
      if (delivered != TOTAL_WORDS || i_dut.checks.failed) begin
         $display("SIMULATION FAILED");
         $fatal(1, "Run ended with a failed check");
      end else begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

   // First assertion error ends the run
   always @(posedge dram_clk) begin
      if (i_dut.checks.failed) begin
         $display("SIMULATION FAILED");
         $fatal(1, "A bound assertion failed, see the error above");
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge dram_clk);
      $display("SIMULATION FAILED");
      $fatal(1, "Watchdog expired with %0d of %0d words delivered", delivered, TOTAL_WORDS);
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the bench with Verilator, run it, then look for the pass line in the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module dram_fifo_tb -f dram_fifo.f -o dram_fifo_sim

# Let the bench report bound assertion errors itself
./obj_dir/dram_fifo_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

grep -q "^SIMULATION PASSED$" sim.log

// File: verilog/axi_burst_master.sv
/* Single-ID AXI4 master with fixed 8-byte INCR bursts. Response codes are ignored,
   and write data is expected to be waiting in the input buffer */
`timescale 1ns/10ps
module axi_burst_master import dram_fifo_pkg::*, axi_burst_pkg::*; (
   input  logic  dram_clk,
   input  logic  input_timeout_reset,
   burst_cmd_if.executor wr_cmd,
   burst_cmd_if.executor rd_cmd,
   // Write stream from the input buffer
   input  word_t i_wr_data,
   input  logic  i_wr_valid,
   output logic  o_wr_ready,
   // Read stream to the output buffer
   output word_t o_rd_data,
   output logic  o_rd_valid,
   input  logic  i_rd_ready,
   // AXI write channels
   output addr_t o_awaddr,
   output len_t  o_awlen,
   output logic  o_awvalid,
   input  logic  i_awready,
   output word_t o_wdata,
   output logic  o_wlast,
   output logic  o_wvalid,
   input  logic  i_wready,
   input  logic  i_bvalid,
   output logic  o_bready,
   // AXI read channels
   output addr_t o_araddr,
   output len_t  o_arlen,
   output logic  o_arvalid,
   input  logic  i_arready,
   input  word_t i_rdata,
   input  logic  i_rlast,
   input  logic  i_rvalid,
   output logic  o_rready
);

   typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} wr_state_t;
   typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} rd_state_t;

   wr_state_t wr_state;
   rd_state_t rd_state;
   len_t      wr_beat;                           // Beats sent so far
   logic      w_fire;
   logic      r_fire;

   ///////////////////////////////////////////////////////////////////////
   // Write channel, AW then len+1 beats then B

   assign wr_cmd.ready = (wr_state == W_IDLE);
   assign o_awvalid    = (wr_state == W_ADDR);
   assign o_wvalid     = i_wr_valid & (wr_state == W_DATA);
   assign o_wr_ready   = i_wready & (wr_state == W_DATA); // Pops the input buffer
   assign o_wdata      = i_wr_data;
   assign o_wlast      = (wr_state == W_DATA) && (wr_beat == o_awlen);
   assign o_bready     = 1'b1;
   assign w_fire       = o_wvalid & i_wready;

   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         wr_state <= W_IDLE;
         wr_beat  <= '0;
      end else begin
         case (wr_state)
            W_IDLE: begin
               if (wr_cmd.valid) begin
                  o_awaddr <= wr_cmd.cmd.addr;
                  o_awlen  <= wr_cmd.cmd.len;
                  wr_state <= W_ADDR;
               end
            end
            W_ADDR: begin
               wr_beat <= '0;
               if (i_awready) wr_state <= W_DATA;
            end
            W_DATA: begin
               if (w_fire) begin
                  wr_beat <= wr_beat + 1'b1;
                  if (o_wlast) wr_state <= W_RESP;
               end
            end
            W_RESP: begin
               if (i_bvalid) wr_state <= W_IDLE; // Burst now in DRAM
            end
            default: wr_state <= W_IDLE;
         endcase
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Read channel, AR then beats until rlast

   assign rd_cmd.ready = (rd_state == R_IDLE);
   assign o_arvalid    = (rd_state == R_ADDR);
   assign o_rready     = i_rd_ready & (rd_state == R_DATA); // Room is reserved by the scheduler
   assign o_rd_valid   = i_rvalid & (rd_state == R_DATA);
   assign o_rd_data    = i_rdata;
   assign r_fire       = i_rvalid & o_rready;

   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         rd_state <= R_IDLE;
      end else begin
         case (rd_state)
            R_IDLE: begin
               if (rd_cmd.valid) begin
                  o_araddr <= rd_cmd.cmd.addr;
                  o_arlen  <= rd_cmd.cmd.len;
                  rd_state <= R_ADDR;
               end
            end
            R_ADDR: begin
               if (i_arready) rd_state <= R_DATA;
            end
            R_DATA: begin
               if (r_fire && i_rlast) rd_state <= R_IDLE;
            end
            default: rd_state <= R_IDLE;
         endcase
      end
   end

endmodule

// File: verilog/axi_burst_pkg.sv
/* Only 8-byte INCR bursts on a single ID are issued */
package axi_burst_pkg;

   localparam int LEN_W = 8;                     // AXI4 awlen / arlen width

   typedef logic [LEN_W-1:0] len_t;              // Beats minus one

   localparam logic [2:0] AXI_BEAT_SIZE = 3'b011; // 2^3 bytes per beat
   localparam logic [1:0] AXI_INCR      = 2'b01;  // Incrementing burst

   // One burst request from a scheduler
   typedef struct packed {
      dram_fifo_pkg::addr_t addr;                // First byte, 8-byte aligned
      len_t                 len;                 // Beats minus one
   } burst_cmd_t;

endpackage

// File: verilog/burst_cmd_if.sv
/* One burst in flight per instance.
   Ready falls the cycle after accept and returns when the burst is finished */
`timescale 1ns/10ps
interface burst_cmd_if import axi_burst_pkg::*; ();

   burst_cmd_t cmd;                              // Start address and length
   logic       valid;                            // Held until accepted
   logic       ready;                            // Executor channel idle

   // Scheduler side
   modport requester (
      output cmd,
      output valid,
      input  ready
   );

   // AXI master side
   modport executor (
      input  cmd,
      input  valid,
      output ready
   );

endinterface

// File: verilog/burst_scheduler.sv
/* One burst at a time. Base, mask and timeout are taken only while reset is high,
   and the mask must leave at least the low 12 address bits free */
`timescale 1ns/10ps
module burst_scheduler import dram_fifo_pkg::*, axi_burst_pkg::*; (
   input  logic          dram_clk,
   input  logic          input_timeout_reset,
   input  addr_t         i_base_addr,
   input  addr_t         i_addr_mask,            // Ones mark fixed address bits
   input  logic [11:0]   i_timeout,              // Idle cycles before a short burst
   input  wcount_t       i_level,                // Words waiting at the source
   input  wcount_t       i_room,                 // Words free at the destination
   burst_cmd_if.requester cmd,
   output logic          o_commit,               // One-cycle pulse per finished burst
   output len_t          o_commit_len
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_FULL,                                    // Size a full burst
      S_TIMEOUT,                                 // Size a fragment
      S_ACCEPT,                                  // Wait for accept
      S_FALL,                                    // Wait for ready to drop
      S_RETURN,                                  // Wait for burst done
      S_SETTLE                                   // Let the counts catch up
   } state_t;

   state_t      state;
   addr_t       fixed_bits;                      // Base bits under the mask
   addr_t       mask_bar;                        // Bits that wrap inside the region
   logic [11:0] timeout_q;
   logic [11:0] tmo_count;
   logic        tmo_flag;
   addr_t       addr_q;                          // Start of the next burst
   len_t        len_q;
   addr_t       burst_bytes;
   wcount_t     page_left;                       // Words before the 4 KB edge
   wcount_t     full_words;
   wcount_t     tmo_words;
   logic        trigger;

   ///////////////////////////////////////////////////////////////////////
   // Sizing and trigger

   assign page_left = wcount_t'(PAGE_BYTES >> WORD_SHIFT)
                    - wcount_t'(addr_q[$clog2(PAGE_BYTES)-1:WORD_SHIFT]);
   assign full_words = (page_left < wcount_t'(BURST_WORDS)) ? page_left : wcount_t'(BURST_WORDS);
   assign tmo_words  = (i_level < full_words) ? i_level : full_words; // Page limit already in
   assign burst_bytes = (addr_t'(len_q) + 1'b1) << AXI_BEAT_SIZE;

   assign trigger = (state == S_IDLE) && (i_room >= wcount_t'(BURST_WORDS))
                 && ((i_level >= wcount_t'(BURST_WORDS)) || (tmo_flag && i_level != '0));

   assign cmd.cmd      = '{addr: addr_q, len: len_q};
   assign o_commit_len = len_q;

   // Configuration
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         fixed_bits <= i_base_addr & i_addr_mask;
         mask_bar   <= ~i_addr_mask;
         timeout_q  <= i_timeout;
      end
   end

   // Fragment timeout, counts only while idle with data waiting
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset || trigger) begin
         tmo_count <= '0;
         tmo_flag  <= 1'b0;
      end else if (tmo_count == timeout_q) begin
         tmo_flag  <= 1'b1;                      // Holds until the next trigger
      end else if (state == S_IDLE && i_level != '0) begin
         tmo_count <= tmo_count + 1'b1;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Burst FSM

   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         state     <= S_IDLE;
         addr_q    <= i_base_addr & i_addr_mask;
         cmd.valid <= 1'b0;
         o_commit  <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (trigger) begin
                  state <= (i_level >= wcount_t'(BURST_WORDS)) ? S_FULL : S_TIMEOUT;
               end
            end
            S_FULL: begin
               len_q     <= len_t'(full_words - 1'b1);
               cmd.valid <= 1'b1;
               state     <= S_ACCEPT;
            end
            S_TIMEOUT: begin
               len_q     <= len_t'(tmo_words - 1'b1);
               cmd.valid <= 1'b1;
               state     <= S_ACCEPT;
            end
            S_ACCEPT: begin
               if (cmd.ready) begin              // Valid is high here
                  cmd.valid <= 1'b0;
                  state     <= S_FALL;
               end
            end
            S_FALL: begin
               if (!cmd.ready) state <= S_RETURN;
            end
            S_RETURN: begin
               if (cmd.ready) begin              // B seen or last R beat taken
                  addr_q   <= ((addr_q + burst_bytes) & mask_bar) | fixed_bits;
                  o_commit <= 1'b1;
                  state    <= S_SETTLE;
               end
            end
            S_SETTLE: begin
               o_commit <= 1'b0;
               state    <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

// File: verilog/dram_fifo_pkg.sv
/* Sizes assume 64-bit words on 8-byte aligned byte addresses.
   A region must be a power of two and no smaller than one 4 KB page */
package dram_fifo_pkg;

   localparam int DATA_W     = 64;               // Stream and DRAM word
   localparam int ADDR_W     = 30;               // Byte address into DRAM
   localparam int WORD_SHIFT = 3;                // Words to bytes

   typedef logic [DATA_W-1:0] word_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [ADDR_W-WORD_SHIFT-1:0] wcount_t; // Word count over the whole address space

   ///////////////////////////////////////////////////////////////////////
   // Burst and buffer limits

   localparam int BURST_WORDS    = 256;          // Longest INCR burst
   localparam int PAGE_BYTES     = 4096;         // AXI page, never crossed by a burst
   localparam int BUF_DEPTH_LOG2 = 10;           // 1024 words in each on-chip buffer

   // Held back from DRAM space
   // Gives the memory controller some room to reorder
   localparam int SPACE_RESERVE  = 64;

endpackage

// File: verilog/dram_fifo_top.sv
/* Base address, mask and timeout are sampled only while reset is high.
   The mask must leave at least the low 12 address bits free */
`timescale 1ns/10ps
module dram_fifo_top import dram_fifo_pkg::*, axi_burst_pkg::*; (
   input  logic        dram_clk,
   input  logic        input_timeout_reset,
   input  addr_t       i_base_addr,
   input  addr_t       i_addr_mask,
   input  logic [11:0] i_timeout,
   // Input stream
   input  word_t       i_tdata,
   input  logic        i_tvalid,
   output logic        i_tready,
   // Output stream
   output word_t       o_tdata,
   output logic        o_tvalid,
   input  logic        o_tready,
   // AXI write
   output addr_t       o_awaddr,
   output len_t        o_awlen,
   output logic        o_awvalid,
   input  logic        i_awready,
   output word_t       o_wdata,
   output logic        o_wlast,
   output logic        o_wvalid,
   input  logic        i_wready,
   input  logic        i_bvalid,
   output logic        o_bready,
   // AXI read
   output addr_t       o_araddr,
   output len_t        o_arlen,
   output logic        o_arvalid,
   input  logic        i_arready,
   input  word_t       i_rdata,
   input  logic        i_rlast,
   input  logic        i_rvalid,
   output logic        o_rready
);

   word_t   wr_data;                             // Input buffer to master
   logic    wr_valid;
   logic    wr_ready;
   word_t   rd_data;                             // Master to output buffer
   logic    rd_valid;
   logic    rd_ready;
   wcount_t in_level;
   wcount_t out_room;
   wcount_t dram_words;
   wcount_t dram_space;
   logic    wr_commit;
   len_t    wr_len;
   logic    rd_commit;
   len_t    rd_len;

   burst_cmd_if wr_cmd ();
   burst_cmd_if rd_cmd ();

   stream_fifo #(.T(word_t), .DEPTH_LOG2(BUF_DEPTH_LOG2)) in_buf (
      .dram_clk, .input_timeout_reset,
      .i_data(i_tdata), .i_valid(i_tvalid), .o_ready_up(i_tready),
      .o_data(wr_data), .o_valid(wr_valid), .i_ready_dn(wr_ready),
      .o_occupied(in_level), .o_space());

   stream_fifo #(.T(word_t), .DEPTH_LOG2(BUF_DEPTH_LOG2)) out_buf (
      .dram_clk, .input_timeout_reset,
      .i_data(rd_data), .i_valid(rd_valid), .o_ready_up(rd_ready),
      .o_data(o_tdata), .o_valid(o_tvalid), .i_ready_dn(o_tready),
      .o_occupied(), .o_space(out_room));

   // Writes move input buffer words into DRAM space
   burst_scheduler wr_sched (
      .dram_clk, .input_timeout_reset, .i_base_addr, .i_addr_mask, .i_timeout,
      .i_level(in_level), .i_room(dram_space), .cmd(wr_cmd.requester),
      .o_commit(wr_commit), .o_commit_len(wr_len));

   // Reads move DRAM words into the output buffer
   burst_scheduler rd_sched (
      .dram_clk, .input_timeout_reset, .i_base_addr, .i_addr_mask, .i_timeout,
      .i_level(dram_words), .i_room(out_room), .cmd(rd_cmd.requester),
      .o_commit(rd_commit), .o_commit_len(rd_len));

   occupancy_tracker tracker (
      .dram_clk, .input_timeout_reset, .i_addr_mask,
      .i_wr_commit(wr_commit), .i_wr_len(wr_len),
      .i_rd_commit(rd_commit), .i_rd_len(rd_len),
      .o_occupied(dram_words), .o_space(dram_space));

   axi_burst_master master (
      .dram_clk, .input_timeout_reset,
      .wr_cmd(wr_cmd.executor), .rd_cmd(rd_cmd.executor),
      .i_wr_data(wr_data), .i_wr_valid(wr_valid), .o_wr_ready(wr_ready),
      .o_rd_data(rd_data), .o_rd_valid(rd_valid), .i_rd_ready(rd_ready),
      .o_awaddr, .o_awlen, .o_awvalid, .i_awready,
      .o_wdata, .o_wlast, .o_wvalid, .i_wready, .i_bvalid, .o_bready,
      .o_araddr, .o_arlen, .o_arvalid, .i_arready,
      .i_rdata, .i_rlast, .i_rvalid, .o_rready);

endmodule

// File: verilog/occupancy_tracker.sv
/* Space starts at the region size less a reserve, from the mask seen during reset.
   Counts are in 64-bit words */
`timescale 1ns/10ps
module occupancy_tracker import dram_fifo_pkg::*, axi_burst_pkg::*; (
   input  logic    dram_clk,
   input  logic    input_timeout_reset,
   input  addr_t   i_addr_mask,
   input  logic    i_wr_commit,                  // Write burst landed in DRAM
   input  len_t    i_wr_len,
   input  logic    i_rd_commit,                  // Read burst taken out of DRAM
   input  len_t    i_rd_len,
   output wcount_t o_occupied,
   output wcount_t o_space
);

   wcount_t wr_words;
   wcount_t rd_words;

   assign wr_words = i_wr_commit ? wcount_t'(i_wr_len) + 1'b1 : '0;
   assign rd_words = i_rd_commit ? wcount_t'(i_rd_len) + 1'b1 : '0;

   // Both commits may land together
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         o_occupied <= '0;
         o_space    <= wcount_t'(~i_addr_mask >> WORD_SHIFT) + 1'b1
                     - wcount_t'(SPACE_RESERVE); // Region words less the reserve
      end else begin
         o_occupied <= o_occupied + wr_words - rd_words;
         o_space    <= o_space - wr_words + rd_words;
      end
   end

endmodule

// File: verilog/stream_fifo.sv
/* The RAM is read combinationally, so a word shows at the output one cycle after the write.
   Stored data is kept through reset */
`timescale 1ns/10ps
module stream_fifo import dram_fifo_pkg::*; #(
   parameter type T          = word_t,           // Payload
   parameter int  DEPTH_LOG2 = BUF_DEPTH_LOG2
) (
   input  logic    dram_clk,
   input  logic    input_timeout_reset,
   input  T        i_data,
   input  logic    i_valid,
   output logic    o_ready_up,                   // Low when full
   output T        o_data,
   output logic    o_valid,
   input  logic    i_ready_dn,
   output wcount_t o_occupied,                   // Words held
   output wcount_t o_space                       // Words free
);

   T                      mem [2**DEPTH_LOG2];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;                 // One bit wider than the pointers
   logic                  push;
   logic                  pop;

   assign push = i_valid & o_ready_up;
   assign pop  = o_valid & i_ready_dn;

   assign o_ready_up = ~count[DEPTH_LOG2];       // Top bit set only when full
   assign o_valid    = |count;
   assign o_data     = mem[rd_ptr];
   assign o_occupied = wcount_t'(count);
   assign o_space    = wcount_t'(2**DEPTH_LOG2) - wcount_t'(count);

   // Storage
   always_ff @(posedge dram_clk) begin
      if (push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // Pointers and fill level
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;             // Wraps at depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;             // Both or neither
         endcase
      end
   end

endmodule
